// File: dv/vrename_stimulus.txt
# test reps ren lreg src free chk rec rck del rb exp_empty exp_oock, free = random picks
# lreg steps up by one per repeat, exp flags hold on the last repeat, 2 = no check
1 32 1 0 3 0 0 0 0 0 0 0 0
2 1 1 4 4 0 0 0 0 0 0 1 0
2 1 1 7 9 2 0 0 0 0 0 0 0
2 8 0 0 2 2 0 0 0 0 0 0 0
2 10 1 0 1 0 0 0 0 0 0 0 0
3 1 1 5 5 0 1 0 0 0 0 0 0
3 3 1 6 6 0 0 0 0 0 0 2 0
3 1 1 9 6 0 0 1 0 0 0 2 0
3 2 1 6 6 0 0 0 0 0 0 2 0
4 4 0 0 6 0 1 0 0 0 0 2 1
4 2 0 0 6 0 0 0 0 1 0 2 0
5 1 1 3 3 1 0 0 0 0 1 2 0
5 3 1 3 3 0 0 0 0 0 0 0 0

// File: sim.f
src/vrename_pkg.sv
src/vmap_wr_if.sv
src/vreg_free_list.sv
src/vrename_ctrl.sv
src/vmap_copy.sv
src/vmap_source_select.sv
src/vrename_top.sv
dv/vrename_checker.sv
dv/tb_vrename.sv

// File: run_sim.sh
#!/bin/sh
# Run from the project root, the testbench opens its stimulus by relative path
set -e
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_vrename \
    -Mdir obj_dir -o sim_vrename
./obj_dir/sim_vrename | tee sim.log
grep -q "SIMULATION PASSED" sim.log

// File: dv/tb_vrename.sv
/* Testbench top, reads dv/vrename_stimulus.txt relative to the project root
   Random frees only pick registers the model has handed out */
`timescale 1ns/1ps
`default_nettype none

module tb_vrename;
    import vrename_pkg::*;

    localparam int NUM_CHECKPOINTS = 4;
    localparam int WAIT_LIMIT      = 10; // Cycles the checker may lag at a test boundary

    logic                               clk_i, rstn_i, rename_i, checkpoint_i;
    logic                               recover_i, delete_ckpt_i, rollback_i;
    lvreg_t                             rename_lreg_i, src_lreg_i;
    logic [1:0]                         free_valid_i;
    phvreg_t [1:0]                      free_preg_i;
    logic [$clog2(NUM_CHECKPOINTS)-1:0] recover_ckpt_i, ckpt_o;
    phvreg_t                            new_preg_o, old_preg_o, src_preg_o, alloc_preg;
    logic                               empty_o, out_of_ckpts_o, alloc_v, aborted;
    logic [1:0]                         flag_empty, flag_oock; // 2 means no check
    int                                 err_cnt, cyc_cnt, n_tests, n_failed;
    phvreg_t                            pool [$];              // Allocated, not yet freed
    logic [31:0]                        rng_state;

    vrename_top #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) vrename_top_i (.*);

    vrename_checker #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) checker_i (
        .clk_i, .rstn_i, .rename_i, .rename_lreg_i, .src_lreg_i, .free_valid_i,
        .free_preg_i, .checkpoint_i, .recover_i, .recover_ckpt_i, .delete_ckpt_i,
        .rollback_i, .new_preg_i(new_preg_o), .old_preg_i(old_preg_o),
        .src_preg_i(src_preg_o), .ckpt_i(ckpt_o), .empty_i(empty_o),
        .oock_i(out_of_ckpts_o), .flag_empty_i(flag_empty), .flag_oock_i(flag_oock),
        .err_cnt_o(err_cnt), .cyc_cnt_o(cyc_cnt), .alloc_v_o(alloc_v),
        .alloc_preg_o(alloc_preg)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i; // 100 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Collects last cycle's allocation before anything else happens on this edge
    task automatic next_cycle();
        @(posedge clk_i);
        if (alloc_v) pool.push_back(alloc_preg);
    endtask

    task automatic pick_free(output phvreg_t p);
        int idx;
        rng_state = xorshift32(rng_state);
        idx       = int'(rng_state % 32'(pool.size()));
        p         = pool[idx];
        pool.delete(idx);
    endtask

    task automatic drive_idle();
        {rename_i, checkpoint_i, recover_i, delete_ckpt_i, rollback_i} <= '0;
        free_valid_i <= '0;
        flag_empty   <= 2'd2;
        flag_oock    <= 2'd2;
    endtask

    task automatic end_test(input int id, input int err_start, input int target);
        int guard;
        guard = 0;
        while (cyc_cnt < target && guard < WAIT_LIMIT) begin
            next_cycle();
            drive_idle();
            guard++;
        end
        if (cyc_cnt < target) begin
            $display("Timeout, checker never reached cycle %0d of test %0d", target, id);
            aborted = 1'b1;
        end else begin
            n_tests++;
            if (err_cnt != err_start) n_failed++;
            $display("test %0d %s, %0d errors", id, (err_cnt == err_start) ? "ok" : "failed",
                     err_cnt - err_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // File-driven stimulus, one line is a segment of identical cycles
    ////////////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        int      fd, n, test, reps, ren, lreg, src, nfree, chk, rec, rck, del, rb, ee, eo;
        int      cur_test, err_start, target;
        phvreg_t p0, p1;
        string   line;
        rstn_i         = 1'b0;
        rename_lreg_i  = '0;
        src_lreg_i     = '0;
        free_preg_i    = '0;
        recover_ckpt_i = '0;
        {rename_i, checkpoint_i, recover_i, delete_ckpt_i, rollback_i} = '0;
        free_valid_i   = '0;
        flag_empty     = 2'd2;
        flag_oock      = 2'd2;
        rng_state      = 32'd79;
        aborted        = 1'b0;
        n_tests        = 0;
        n_failed       = 0;
        cur_test       = 0;
        err_start      = 0;
        target         = 0;
        fd = $fopen("dv/vrename_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file dv/vrename_stimulus.txt");
            aborted = 1'b1;
        end
        repeat (4) next_cycle();
        rstn_i <= 1'b1;
        while (!aborted && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue; // Blank or column legend
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d", test, reps, ren, lreg,
                        src, nfree, chk, rec, rck, del, rb, ee, eo);
            if (n != 13) continue;
            if (test != cur_test) begin
                if (cur_test > 0) end_test(cur_test, err_start, target);
                cur_test  = test;
                err_start = err_cnt;
            end
            for (int k = 0; k < reps && !aborted; k++) begin
                next_cycle();
                p0 = '0;
                p1 = '0;
                if (nfree > 0) pick_free(p0);
                if (nfree > 1) pick_free(p1);
                rename_i       <= (ren != 0);
                rename_lreg_i  <= lvreg_t'(lreg + k); // Destination walks up per cycle
                src_lreg_i     <= lvreg_t'(src);
                free_valid_i   <= {nfree > 1, nfree > 0};
                free_preg_i    <= {p1, p0};
                checkpoint_i   <= (chk != 0);
                recover_i      <= (rec != 0);
                recover_ckpt_i <= ($clog2(NUM_CHECKPOINTS))'(rck);
                delete_ckpt_i  <= (del != 0);
                rollback_i     <= (rb != 0);
                flag_empty     <= (k == reps - 1) ? 2'(ee) : 2'd2; // Flags on last cycle only
                flag_oock      <= (k == reps - 1) ? 2'(eo) : 2'd2;
                target = cyc_cnt + 1;
            end
        end
        if (!aborted && cur_test > 0) end_test(cur_test, err_start, target);
        $display("tests %0d, failed %0d, errors %0d, cycles checked %0d",
                 n_tests, n_failed, err_cnt, cyc_cnt);
        if (!aborted && n_failed == 0 && err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/vrename_checker.sv
/* Reference model of free list, versions and map copies, compared on every falling edge
   Counts assume every wrong value is an error, there is no tolerance window */
`timescale 1ns/1ps
`default_nettype none

module vrename_checker #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire                               clk_i,
    input  wire                               rstn_i,
    input  wire                               rename_i,
    input  wire vrename_pkg::lvreg_t          rename_lreg_i,
    input  wire vrename_pkg::lvreg_t          src_lreg_i,
    input  wire [1:0]                         free_valid_i,
    input  wire vrename_pkg::phvreg_t [1:0]   free_preg_i,
    input  wire                               checkpoint_i,
    input  wire                               recover_i,
    input  wire [$clog2(NUM_CHECKPOINTS)-1:0] recover_ckpt_i,
    input  wire                               delete_ckpt_i,
    input  wire                               rollback_i,
    input  wire vrename_pkg::phvreg_t         new_preg_i,    // DUT outputs
    input  wire vrename_pkg::phvreg_t         old_preg_i,
    input  wire vrename_pkg::phvreg_t         src_preg_i,
    input  wire [$clog2(NUM_CHECKPOINTS)-1:0] ckpt_i,
    input  wire                               empty_i,
    input  wire                               oock_i,
    input  wire [1:0]                         flag_empty_i,  // From the stimulus file, 2 skips
    input  wire [1:0]                         flag_oock_i,
    output int                                err_cnt_o,
    output int                                cyc_cnt_o,     // Cycles compared so far
    output logic                              alloc_v_o,     // Model allocated this cycle
    output vrename_pkg::phvreg_t              alloc_preg_o
);
    import vrename_pkg::*;

    localparam int N = NUM_CHECKPOINTS;

    phvreg_t fifo_m [NUM_FREE_ENTRIES]; // Free-list slots
    int      head_m [N];                // Head and count per version
    int      cnt_m  [N];
    int      tail_m, vh, vt, nck, label_m;
    vmap_t   map_m  [N];                // One map per checkpoint copy

    task automatic compare_value(input string name, input int exp, input int got);
        if (exp != got) begin
            err_cnt_o++;
            $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare mid-cycle, then step the model to the state after the next edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin : model_step
        int   cc, nadd, nv, exp_new;
        logic w0, w1, grant, ck_en;
        if (!rstn_i) begin
            for (int i = 0; i < NUM_FREE_ENTRIES; i++) fifo_m[i] = phvreg_t'(i + NUM_ISA_VREGS);
            for (int c = 0; c < N; c++) begin
                head_m[c] = 0;
                cnt_m[c]  = NUM_FREE_ENTRIES;
                for (int l = 0; l < NUM_ISA_VREGS; l++) map_m[c][l] = phvreg_t'(l);
            end
            tail_m    = 0;
            vh        = 0;
            vt        = 0;
            nck       = 0;
            label_m   = 0;
            err_cnt_o = 0;
            cyc_cnt_o = 0;
            alloc_v_o = 1'b0;
        end else begin
            w0      = free_valid_i[0] && !rollback_i; // Rollback drops frees
            w1      = free_valid_i[1] && !rollback_i;
            nadd    = int'(w0) + int'(w1);
            cc      = cnt_m[vh];
            grant   = rename_i && (cc > 0 || w0 || w1) && !recover_i && !rollback_i;
            ck_en   = checkpoint_i && (nck < N - 1) && !recover_i && !rollback_i;
            if (!grant)       exp_new = 0;
            else if (cc == 0) exp_new = w0 ? int'(free_preg_i[0]) : int'(free_preg_i[1]);
            else              exp_new = int'(fifo_m[head_m[vh]]);

            compare_value("new_preg_o", exp_new, int'(new_preg_i));
            compare_value("old_preg_o", int'(map_m[vh][rename_lreg_i]), int'(old_preg_i));
            compare_value("src_preg_o", int'(map_m[vh][src_lreg_i]), int'(src_preg_i));
            compare_value("ckpt_o", label_m, int'(ckpt_i));
            compare_value("empty_o", int'(cc == 0 && !w0 && !w1), int'(empty_i));
            compare_value("out_of_ckpts_o", int'(nck == N - 1), int'(oock_i));
            if (flag_empty_i != 2'd2) compare_value("empty_o", int'(flag_empty_i), int'(empty_i));
            if (flag_oock_i != 2'd2) compare_value("out_of_ckpts_o", int'(flag_oock_i), int'(oock_i));
            alloc_v_o    = grant;
            alloc_preg_o = phvreg_t'(exp_new);
            cyc_cnt_o++;

            if (rollback_i) begin
                vh        = 0;
                vt        = 0;
                nck       = 0;
                label_m   = 0;
                head_m[0] = tail_m;           // Whole list free again from the tail
                cnt_m[0]  = NUM_FREE_ENTRIES;
            end else begin
                if (w0) fifo_m[tail_m] = free_preg_i[0];
                if (w1) fifo_m[(tail_m + int'(w0)) % NUM_FREE_ENTRIES] = free_preg_i[1];
                tail_m  = (tail_m + nadd) % NUM_FREE_ENTRIES;
                label_m = vh;                 // Label lags the version by one cycle
                for (int c = 0; c < N; c++) cnt_m[c] += nadd;
                if (recover_i) begin
                    nck = (int'(recover_ckpt_i) - vt + N) % N; // Old tail on purpose
                    vh  = int'(recover_ckpt_i);
                end else begin
                    nck = nck + int'(ck_en) - int'(delete_ckpt_i);
                    if (grant) begin
                        head_m[vh] = (head_m[vh] + 1) % NUM_FREE_ENTRIES;
                        cnt_m[vh]--;
                        map_m[vh][rename_lreg_i] = phvreg_t'(exp_new);
                    end
                    if (ck_en) begin          // New version starts after this rename
                        nv         = (vh + 1) % N;
                        head_m[nv] = head_m[vh];
                        cnt_m[nv]  = cnt_m[vh];
                        map_m[nv]  = map_m[vh];
                        vh         = nv;
                    end
                end
                vt = (vt + int'(delete_ckpt_i)) % N;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/vrename_top.sv
/* Vector register rename stage, one rename and up to two frees per cycle
   No back-pressure, a rename while empty_o is high returns 0 and is dropped */
`timescale 1ns/1ps
`default_nettype none

module vrename_top #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire                                clk_i,
    input  wire                                rstn_i,
    input  wire                                rename_i,
    input  wire vrename_pkg::lvreg_t           rename_lreg_i,
    input  wire vrename_pkg::lvreg_t           src_lreg_i,
    input  wire [1:0]                          free_valid_i,
    input  wire vrename_pkg::phvreg_t [1:0]    free_preg_i,
    input  wire                                checkpoint_i,
    input  wire                                recover_i,
    input  wire [$clog2(NUM_CHECKPOINTS)-1:0]  recover_ckpt_i,
    input  wire                                delete_ckpt_i,
    input  wire                                rollback_i,
    output vrename_pkg::phvreg_t               new_preg_o,
    output vrename_pkg::phvreg_t               old_preg_o,
    output vrename_pkg::phvreg_t               src_preg_o,
    output logic [$clog2(NUM_CHECKPOINTS)-1:0] ckpt_o,
    output logic                               empty_o,
    output logic                               out_of_ckpts_o
);
    import vrename_pkg::*;

    vmap_t [NUM_CHECKPOINTS-1:0]        all_maps;    // One packed map per copy
    logic [$clog2(NUM_CHECKPOINTS)-1:0] active_ckpt;

    vmap_wr_if #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) map_wr ();

    vrename_ctrl #(
        .NUM_CHECKPOINTS (NUM_CHECKPOINTS)
    ) ctrl_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .rename_i       (rename_i),
        .rename_lreg_i  (rename_lreg_i),
        .checkpoint_i   (checkpoint_i),
        .recover_i      (recover_i),
        .recover_ckpt_i (recover_ckpt_i),
        .delete_ckpt_i  (delete_ckpt_i),
        .rollback_i     (rollback_i),
        .free_valid_i   (free_valid_i),
        .free_preg_i    (free_preg_i),
        .new_preg_o     (new_preg_o),
        .ckpt_o         (ckpt_o),
        .active_ckpt_o  (active_ckpt),
        .empty_o        (empty_o),
        .out_of_ckpts_o (out_of_ckpts_o),
        .map_wr         (map_wr)
    );

    // Ring of map copies, each loads from its predecessor on a checkpoint
    for (genvar g = 0; g < NUM_CHECKPOINTS; g++) begin : g_copy
        vmap_copy #(
            .NUM_CHECKPOINTS (NUM_CHECKPOINTS),
            .COPY_IDX        (g)
        ) copy_i (
            .clk_i     (clk_i),
            .rstn_i    (rstn_i),
            .map_wr    (map_wr),
            .src_map_i (all_maps[(g + NUM_CHECKPOINTS - 1) % NUM_CHECKPOINTS]),
            .map_o     (all_maps[g])
        );
    end

    vmap_source_select #(
        .NUM_CHECKPOINTS (NUM_CHECKPOINTS)
    ) select_i (
        .all_maps_i    (all_maps),
        .active_ckpt_i (active_ckpt),
        .rename_lreg_i (rename_lreg_i),
        .src_lreg_i    (src_lreg_i),
        .old_preg_o    (old_preg_o),
        .src_preg_o    (src_preg_o)
    );

endmodule

`default_nettype wire

// File: src/vmap_source_select.sv
/* Picks the active map copy, then looks up destination and source registers
   Purely combinational, lookups see the map before this cycle's rename */
`timescale 1ns/1ps
`default_nettype none

module vmap_source_select #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire vrename_pkg::vmap_t [NUM_CHECKPOINTS-1:0] all_maps_i,
    input  wire [$clog2(NUM_CHECKPOINTS)-1:0]             active_ckpt_i,
    input  wire vrename_pkg::lvreg_t                      rename_lreg_i,
    input  wire vrename_pkg::lvreg_t                      src_lreg_i,
    output vrename_pkg::phvreg_t                          old_preg_o,
    output vrename_pkg::phvreg_t                          src_preg_o
);
    import vrename_pkg::*;

    vmap_t active_map;

    assign active_map = all_maps_i[active_ckpt_i];   // First level, version
    assign old_preg_o = active_map[rename_lreg_i];   // Mapping being replaced
    assign src_preg_o = active_map[src_lreg_i];      // Source operand lookup

endmodule

`default_nettype wire

// File: src/vmap_copy.sv
/* One checkpoint copy of the logical-to-physical map, resets to identity
   src_map_i must be the copy just before this one in the ring */
`timescale 1ns/1ps
`default_nettype none

module vmap_copy #(
    parameter int NUM_CHECKPOINTS = 4,
    parameter int COPY_IDX        = 0
) (
    input  wire                clk_i,
    input  wire                rstn_i,
    vmap_wr_if.copy            map_wr,
    input  wire vrename_pkg::vmap_t src_map_i, // Previous copy, source of a checkpoint
    output vrename_pkg::vmap_t      map_o
);
    import vrename_pkg::*;

    localparam int CKPT_W = $clog2(NUM_CHECKPOINTS);

    vmap_t map_q;
    logic  is_active;  // Takes rename writes
    logic  load_ckpt;  // Loads the active copy

    assign is_active = (map_wr.active_ckpt == CKPT_W'(COPY_IDX));
    assign load_ckpt = map_wr.ckpt_take & (map_wr.ckpt_dst == CKPT_W'(COPY_IDX));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            map_q <= identity_map();
        end else if (load_ckpt) begin
            map_q <= src_map_i;
            // Rename of the same cycle belongs in the new checkpoint
            if (map_wr.wr_en) map_q[map_wr.wr_lreg] <= map_wr.wr_preg;
        end else if (is_active && map_wr.wr_en) begin
            map_q[map_wr.wr_lreg] <= map_wr.wr_preg;
        end
    end

    assign map_o = map_q; // Read is combinational through the selector

endmodule

`default_nettype wire

// File: src/vrename_ctrl.sv
/* Rename and checkpoint control, grants at most one rename per cycle
   Recover and rollback block the rename of their cycle */
`timescale 1ns/1ps
`default_nettype none

module vrename_ctrl #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire                                clk_i,
    input  wire                                rstn_i,
    input  wire                                rename_i,
    input  wire vrename_pkg::lvreg_t           rename_lreg_i,
    input  wire                                checkpoint_i,
    input  wire                                recover_i,
    input  wire [$clog2(NUM_CHECKPOINTS)-1:0]  recover_ckpt_i,
    input  wire                                delete_ckpt_i,
    input  wire                                rollback_i,
    input  wire [1:0]                          free_valid_i,
    input  wire vrename_pkg::phvreg_t [1:0]    free_preg_i,
    output vrename_pkg::phvreg_t               new_preg_o,
    output logic [$clog2(NUM_CHECKPOINTS)-1:0] ckpt_o,
    output logic [$clog2(NUM_CHECKPOINTS)-1:0] active_ckpt_o,
    output logic                               empty_o,
    output logic                               out_of_ckpts_o,
    vmap_wr_if.ctrl                            map_wr
);

    logic rename_grant; // Rename that really allocates
    logic ckpt_take;    // Mirrors the free list checkpoint enable

    assign rename_grant = rename_i & ~empty_o & ~recover_i & ~rollback_i;
    assign ckpt_take    = checkpoint_i & ~out_of_ckpts_o & ~recover_i & ~rollback_i;

    vreg_free_list #(
        .NUM_CHECKPOINTS (NUM_CHECKPOINTS)
    ) free_list_i (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (rename_grant),
        .add_free_register_i  (free_valid_i),
        .free_register_i      (free_preg_i),
        .do_checkpoint_i      (checkpoint_i),
        .do_recover_i         (recover_i),
        .delete_checkpoint_i  (delete_ckpt_i),
        .recover_checkpoint_i (recover_ckpt_i),
        .commit_roll_back_i   (rollback_i),
        .new_register_o       (new_preg_o),
        .checkpoint_o         (ckpt_o),
        .version_o            (active_ckpt_o),
        .out_of_checkpoints_o (out_of_ckpts_o),
        .empty_o              (empty_o)
    );

    // Map commands, write goes to the active copy
    assign map_wr.wr_en       = rename_grant;
    assign map_wr.wr_lreg     = rename_lreg_i;
    assign map_wr.wr_preg     = new_preg_o;
    assign map_wr.active_ckpt = active_ckpt_o;
    assign map_wr.ckpt_take   = ckpt_take;
    assign map_wr.ckpt_dst    = active_ckpt_o + 1'b1; // Next copy in the ring

    // A taken checkpoint makes its destination copy the active version
    a_ckpt_take: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ckpt_take |=> (active_ckpt_o == $past(map_wr.ckpt_dst)));

endmodule

`default_nettype wire

// File: src/vreg_free_list.sv
/* Checkpointed circular free list, two frees and one allocation per cycle
   Callers must not raise read_head_i while empty_o is high */
`timescale 1ns/1ps
`default_nettype none

module vreg_free_list #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire                                clk_i,
    input  wire                                rstn_i,
    input  wire                                read_head_i,          // Allocate from head
    input  wire [1:0]                          add_free_register_i,  // Free strobes
    input  wire vrename_pkg::phvreg_t [1:0]    free_register_i,      // Registers being freed
    input  wire                                do_checkpoint_i,      // Checkpoint after this read
    input  wire                                do_recover_i,         // Switch to recover label
    input  wire                                delete_checkpoint_i,  // Retire oldest checkpoint
    input  wire [$clog2(NUM_CHECKPOINTS)-1:0]  recover_checkpoint_i,
    input  wire                                commit_roll_back_i,   // Back to version 0
    output vrename_pkg::phvreg_t               new_register_o,
    output logic [$clog2(NUM_CHECKPOINTS)-1:0] checkpoint_o,         // Label of last cycle's version
    output logic [$clog2(NUM_CHECKPOINTS)-1:0] version_o,            // Active version
    output logic                               out_of_checkpoints_o,
    output logic                               empty_o
);
    import vrename_pkg::*;

    localparam int PTR_W  = $clog2(NUM_FREE_ENTRIES);
    localparam int CKPT_W = $clog2(NUM_CHECKPOINTS);

    typedef logic [PTR_W-1:0]  fl_ptr_t;       // Slot pointer
    typedef logic [PTR_W:0]    fl_cnt_t;       // One bit wider to hold a full list
    typedef logic [CKPT_W-1:0] checkpoint_ptr;
    typedef logic [CKPT_W:0]   ckpt_cnt_t;     // Live checkpoints, one bit wider

    phvreg_t       table_q [NUM_FREE_ENTRIES]; // FIFO storage
    fl_ptr_t       head_q  [NUM_CHECKPOINTS];  // Head per version
    fl_cnt_t       cnt_q   [NUM_CHECKPOINTS];  // Free count per version
    fl_ptr_t       tail_q;                     // Shared by all versions
    checkpoint_ptr version_head_q;             // Active version
    checkpoint_ptr version_tail_q;             // Oldest live checkpoint
    ckpt_cnt_t     num_ckpt_q;

    logic          we0, we1, rd_en, ckpt_en;
    fl_cnt_t       n_add;                      // Frees this cycle, 0 to 2
    fl_ptr_t       cur_head, next_head;
    fl_cnt_t       cur_cnt, next_cnt;
    checkpoint_ptr next_version;

    assign cur_head     = head_q[version_head_q];
    assign cur_cnt      = cnt_q[version_head_q];
    assign next_version = version_head_q + 1'b1;

    // Frees are dropped on rollback, reads also on recover
    assign we0     = add_free_register_i[0] & ~commit_roll_back_i;
    assign we1     = add_free_register_i[1] & ~commit_roll_back_i;
    assign n_add   = fl_cnt_t'(we0) + fl_cnt_t'(we1);
    assign rd_en   = read_head_i & ((cur_cnt != '0) | we0 | we1)
                   & ~do_recover_i & ~commit_roll_back_i;
    assign ckpt_en = do_checkpoint_i & (num_ckpt_q < ckpt_cnt_t'(NUM_CHECKPOINTS - 1))
                   & ~do_recover_i & ~commit_roll_back_i;

    assign next_head = cur_head + fl_ptr_t'(rd_en);
    assign next_cnt  = cur_cnt + n_add - fl_cnt_t'(rd_en); // Read only hits active version

    ////////////////////////////////////////////////////////////////////////////
    // Freed register storage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_FREE_ENTRIES; i++) begin
                table_q[i] <= free_slot_init(i);
            end
        end else if (we0) begin
            table_q[tail_q] <= free_register_i[0];
            if (we1) table_q[tail_q + 1'b1] <= free_register_i[1]; // Second slot after tail
        end else if (we1) begin
            table_q[tail_q] <= free_register_i[1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers, counts and versions
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_head_q <= '0;
            version_tail_q <= '0;
            num_ckpt_q     <= '0;
            tail_q         <= '0;
            checkpoint_o   <= '0;
            for (int i = 0; i < NUM_CHECKPOINTS; i++) begin
                head_q[i] <= '0;
                cnt_q[i]  <= fl_cnt_t'(NUM_FREE_ENTRIES); // Whole list free
            end
        end else if (commit_roll_back_i) begin
            // Everything in flight goes back, list refills from the tail
            version_head_q <= '0;
            version_tail_q <= '0;
            num_ckpt_q     <= '0;
            head_q[0]      <= tail_q;
            cnt_q[0]       <= fl_cnt_t'(NUM_FREE_ENTRIES);
            checkpoint_o   <= '0;
        end else begin
            version_tail_q <= version_tail_q + checkpoint_ptr'(delete_checkpoint_i);
            tail_q         <= tail_q + fl_ptr_t'(n_add);
            checkpoint_o   <= version_head_q;
            for (int i = 0; i < NUM_CHECKPOINTS; i++) begin
                cnt_q[i] <= cnt_q[i] + n_add; // Frees land in every version
            end

            if (do_recover_i) begin
                version_head_q <= recover_checkpoint_i;
                // Live checkpoints between oldest and recovered label, with wrap
                if (recover_checkpoint_i >= version_tail_q)
                    num_ckpt_q <= {1'b0, recover_checkpoint_i - version_tail_q};
                else
                    num_ckpt_q <= ckpt_cnt_t'(NUM_CHECKPOINTS) - {1'b0, version_tail_q}
                                + {1'b0, recover_checkpoint_i};
            end else begin
                num_ckpt_q <= num_ckpt_q + ckpt_cnt_t'(ckpt_en)
                            - ckpt_cnt_t'(delete_checkpoint_i);
                head_q[version_head_q] <= next_head;
                cnt_q[version_head_q]  <= next_cnt;
                if (ckpt_en) begin
                    version_head_q       <= next_version;
                    head_q[next_version] <= next_head; // New version starts post-read
                    cnt_q[next_version]  <= next_cnt;
                end
            end
        end
    end

    // Same-cycle free bypasses to the head when the list is drained
    always_comb begin
        if (!rd_en)
            new_register_o = '0;
        else if ((cur_cnt == '0) && we0)
            new_register_o = free_register_i[0];
        else if ((cur_cnt == '0) && we1)
            new_register_o = free_register_i[1];
        else
            new_register_o = table_q[cur_head];
    end

    assign version_o            = version_head_q;
    assign empty_o              = (cur_cnt == '0) & ~we0 & ~we1;
    assign out_of_checkpoints_o = (num_ckpt_q == ckpt_cnt_t'(NUM_CHECKPOINTS - 1));

    // Frees never outrun allocations, so no version can overfill
    a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cur_cnt <= fl_cnt_t'(NUM_FREE_ENTRIES));

    // Control block gates its reads with empty_o
    a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        read_head_i |-> !empty_o);

endmodule

`default_nettype wire

// File: src/vmap_wr_if.sv
/* Map write and checkpoint-copy commands, one driver and every map copy listening
   Each copy decodes active_ckpt and ckpt_dst against its own index */
`timescale 1ns/1ps
`default_nettype none

interface vmap_wr_if #(
    parameter int NUM_CHECKPOINTS = 4
);
    import vrename_pkg::*;

    logic                               wr_en;       // Granted rename write
    lvreg_t                             wr_lreg;     // Destination logical reg
    phvreg_t                            wr_preg;     // Newly allocated physical reg
    logic [$clog2(NUM_CHECKPOINTS)-1:0] active_ckpt; // Copy that takes wr_en
    logic                               ckpt_take;   // Copy active map into ckpt_dst
    logic [$clog2(NUM_CHECKPOINTS)-1:0] ckpt_dst;    // Always active + 1

    modport ctrl (output wr_en, wr_lreg, wr_preg, active_ckpt, ckpt_take, ckpt_dst);
    modport copy (input  wr_en, wr_lreg, wr_preg, active_ckpt, ckpt_take, ckpt_dst);

endinterface

`default_nettype wire

// File: src/vrename_pkg.sv
/* Register counts and types shared by the vector rename stage
   Map entries and free-list slots come out of reset through the functions below */
`default_nettype none

package vrename_pkg;

    localparam int NUM_ISA_VREGS    = 32;                             // Logical vector registers
    localparam int NUM_PHYS_VREGS   = 64;                             // Physical vector registers
    localparam int NUM_FREE_ENTRIES = NUM_PHYS_VREGS - NUM_ISA_VREGS; // Free-list depth

    typedef logic [$clog2(NUM_ISA_VREGS)-1:0]  lvreg_t;  // Logical index
    typedef logic [$clog2(NUM_PHYS_VREGS)-1:0] phvreg_t; // Physical index

    // One full logical-to-physical map, entry i is logical register i
    typedef phvreg_t [NUM_ISA_VREGS-1:0] vmap_t;

    // Reset map, logical i sits in physical i
    function automatic vmap_t identity_map();
        vmap_t m;
        for (int i = 0; i < NUM_ISA_VREGS; i++) begin
            m[i] = phvreg_t'(i);
        end
        return m;
    endfunction

    // Reset free list, slot s holds physical s + 32
    function automatic phvreg_t free_slot_init(int slot);
        return phvreg_t'(slot + NUM_ISA_VREGS);
    endfunction

endpackage

`default_nettype wire
